// ==== include/mrd_settings.svh ====
`ifndef MRD_SETTINGS_SVH
`define MRD_SETTINGS_SVH

// --------------------------------------------------
// read-side geometry
// --------------------------------------------------

// butterfly lanes, radix 5 at most
`define MRD_LANES 5

// interleaved RAM banks, index 7 marks an idle lane
`define MRD_BANKS 7
`define MRD_BANK_W 3

// sample address, 7 banks x 512 rows
`define MRD_ADDR_W 12
`define MRD_ROW_W 9

// real and imaginary part width
`define MRD_DATA_W 18

// start pulse to first valid butterfly
`define MRD_RD_DLY 5

`endif

// ==== source/mrd_pkg.sv ====
`default_nettype none

`include "mrd_settings.svh"

package mrd_pkg;

	// --------------------------------------------------
	// sample and pass settings
	// --------------------------------------------------

	// one complex sample
	typedef struct packed {
		logic signed [`MRD_DATA_W-1:0] re;
		logic signed [`MRD_DATA_W-1:0] im;
	} cplx_t;

	// per-pass radix and butterfly count
	typedef struct packed {
		logic [2:0] radix;
		logic [`MRD_ADDR_W-1:0] span;
	} rd_cfg_t;

	// --------------------------------------------------
	// memory side
	// --------------------------------------------------

	// read requests, one enable and row per bank
	typedef struct packed {
		logic [`MRD_BANKS-1:0] en;
		logic [`MRD_BANKS-1:0][`MRD_ROW_W-1:0] row;
	} bank_rd_t;

	// registered bank read data
	typedef struct packed {
		cplx_t [`MRD_BANKS-1:0] d;
	} bank_dout_t;

	// linear-address write port
	typedef struct packed {
		logic en;
		logic [`MRD_ADDR_W-1:0] addr;
		cplx_t data;
	} mem_wr_t;

	// lane to bank mapping, bank 7 for unused lanes
	typedef struct packed {
		logic [`MRD_LANES-1:0][`MRD_BANK_W-1:0] bank;
		logic [`MRD_LANES-1:0][`MRD_ROW_W-1:0] row;
	} lane_map_t;

	// butterfly handed to the radix engine
	typedef struct packed {
		logic valid;
		logic [2:0] radix;
		cplx_t [`MRD_LANES-1:0] lane;
	} bfly_t;

endpackage

`default_nettype wire

// ==== source/mrd_div7.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_div7 (
	input  logic [`MRD_ADDR_W-1:0] addr,
	output logic [`MRD_ROW_W-1:0] row,
	output logic [`MRD_BANK_W-1:0] bank
);

	// partial remainder, one spare bit after the shift
	logic [3:0] rem;
	logic [`MRD_ADDR_W-1:0] quo;

	// restoring division, msb first
	always_comb
	begin
		rem = '0;
		quo = '0;
		for (int i = `MRD_ADDR_W-1; i >= 0; i--)
		begin
			// bring down next dividend bit
			rem = {rem[2:0], addr[i]};
			// subtract when the divisor fits
			if (rem >= 4'd7)
			begin
				rem = rem - 4'd7;
				quo[i] = 1'b1;
			end
		end
	end

	// quotient is the row, below 512 for a full frame
	assign row = quo[`MRD_ROW_W-1:0];
	// remainder is the bank
	assign bank = rem[`MRD_BANK_W-1:0];

endmodule

`default_nettype wire

// ==== source/mrd_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_pipe #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input  logic clk,
	input  logic rst_n,
	input  T d,
	output T q
);

	// one entry per cycle of delay
	T stage [DEPTH];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				stage[i] <= '0;
			end
		end
		else
		begin
			stage[0] <= d;
			// shift toward the tail
			for (int i = 1; i < DEPTH; i++)
			begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== source/mrd_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_addr_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  mrd_pkg::rd_cfg_t cfg,
	output logic [`MRD_LANES-1:0][`MRD_ADDR_W-1:0] addr,
	output logic [`MRD_LANES-1:0] lane_en
);

	// butterfly index within the pass
	logic [`MRD_ADDR_W-1:0] base;
	// running lane sum
	logic [`MRD_ADDR_W-1:0] acc;
	logic [`MRD_LANES-1:0][`MRD_ADDR_W-1:0] lane_addr;

	// --------------------------------------------------
	// lane k sits k spans above the base
	// --------------------------------------------------
	always_comb
	begin
		acc = base;
		for (int k = 0; k < `MRD_LANES; k++)
		begin
			lane_addr[k] = acc;
			acc = acc + cfg.span;
		end
	end

	// --------------------------------------------------
	// registered addresses, cleared between passes
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			base <= '0;
			addr <= '0;
			lane_en <= '0;
		end
		else if (run)
		begin
			// next butterfly
			base <= base + 1'b1;
			addr <= lane_addr;
			// only lanes below the radix take part
			for (int k = 0; k < `MRD_LANES; k++)
			begin
				lane_en[k] <= (3'(k) < cfg.radix);
			end
		end
		else
		begin
			// idle, ready for the next pass
			base <= '0;
			addr <= '0;
			lane_en <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/mrd_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_rd_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  mrd_pkg::rd_cfg_t cfg,
	output mrd_pkg::bank_rd_t rd_req,
	input  mrd_pkg::bank_dout_t dout,
	output mrd_pkg::bfly_t bfly,
	output logic rd_end
);

	import mrd_pkg::*;

	// idle lane marker
	localparam logic [`MRD_BANK_W-1:0] NO_BANK = `MRD_BANK_W'(`MRD_BANKS);

	rd_cfg_t cfg_r;
	logic [`MRD_ADDR_W-1:0] cnt;
	logic run;
	logic [`MRD_LANES-1:0][`MRD_ADDR_W-1:0] lane_addr;
	logic [`MRD_LANES-1:0] lane_en;
	logic [`MRD_LANES-1:0][`MRD_ROW_W-1:0] div_row;
	logic [`MRD_LANES-1:0][`MRD_BANK_W-1:0] div_bank;
	lane_map_t map, map_d;
	logic [`MRD_BANKS-1:0] xbar_en;
	logic [`MRD_BANKS-1:0][`MRD_ROW_W-1:0] xbar_row;
	logic vld_s3, vld_s4, vld_s5;
	logic [2:0] radix_d;

	// --------------------------------------------------
	// pass counter, 1..span while running
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (cnt == '0)
		begin
			// starts only accepted when idle
			if (start)
				cnt <= `MRD_ADDR_W'(1);
		end
		else if (cnt == cfg_r.span)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// pass settings held for the whole pass
	always_ff @(posedge clk)
	begin
		if (start && cnt == '0)
			cfg_r <= cfg;
	end

	assign run = (cnt != '0);

	mrd_addr_gen addr_gen_i (
		.clk(clk), .rst_n(rst_n), .run(run), .cfg(cfg_r),
		.addr(lane_addr), .lane_en(lane_en)
	);

	// --------------------------------------------------
	// lane address to bank and row
	// --------------------------------------------------
	for (genvar k = 0; k < `MRD_LANES; k++)
	begin : g_div
		mrd_div7 div7_i (.addr(lane_addr[k]), .row(div_row[k]), .bank(div_bank[k]));
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			map.bank <= {`MRD_LANES{NO_BANK}};
			map.row <= '0;
		end
		else
		begin
			for (int k = 0; k < `MRD_LANES; k++)
			begin
				// disabled lanes point at no bank
				map.bank[k] <= lane_en[k] ? div_bank[k] : NO_BANK;
				map.row[k] <= div_row[k];
			end
		end
	end

	// valid strobe aligned with the lane map
	mrd_pipe #(.T(logic), .DEPTH(`MRD_RD_DLY-3)) vld_pipe_i (
		.clk(clk), .rst_n(rst_n), .d(run), .q(vld_s3)
	);

	// --------------------------------------------------
	// bank crossbar, lanes never share a bank
	// --------------------------------------------------
	always_comb
	begin
		xbar_en = '0;
		xbar_row = '0;
		for (int b = 0; b < `MRD_BANKS; b++)
		begin
			for (int k = 0; k < `MRD_LANES; k++)
			begin
				if (map.bank[k] == `MRD_BANK_W'(b))
				begin
					xbar_en[b] = 1'b1;
					xbar_row[b] = map.row[k];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_req <= '0;
		else
		begin
			rd_req.en <= xbar_en & {`MRD_BANKS{vld_s3}};
			rd_req.row <= xbar_row;
		end
	end

	// --------------------------------------------------
	// output side, follows the RAM latency
	// --------------------------------------------------
	mrd_pipe #(.T(lane_map_t), .DEPTH(`MRD_RD_DLY-3)) map_pipe_i (
		.clk(clk), .rst_n(rst_n), .d(map), .q(map_d)
	);

	// radix travels with its butterflies
	mrd_pipe #(.T(logic [2:0]), .DEPTH(`MRD_RD_DLY-1)) radix_pipe_i (
		.clk(clk), .rst_n(rst_n), .d(cfg_r.radix), .q(radix_d)
	);

	// request and data stages of the strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vld_s4 <= 1'b0;
			vld_s5 <= 1'b0;
			rd_end <= 1'b0;
		end
		else
		begin
			vld_s4 <= vld_s3;
			vld_s5 <= vld_s4;
			// falling edge of the output strobe
			rd_end <= vld_s5 & ~vld_s4;
		end
	end

	// lane select by the delayed bank index
	always_comb
	begin
		bfly.valid = vld_s5;
		bfly.radix = radix_d;
		for (int k = 0; k < `MRD_LANES; k++)
		begin
			bfly.lane[k] = (map_d.bank[k] == NO_BANK) ? '0 : dout.d[map_d.bank[k]];
		end
	end

endmodule

`default_nettype wire

// ==== source/mrd_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_bank_ram (
	input  logic clk,
	input  mrd_pkg::bank_rd_t rd_req,
	output mrd_pkg::bank_dout_t dout,
	input  mrd_pkg::mem_wr_t wr
);

	import mrd_pkg::*;

	localparam int ROWS = 1 << `MRD_ROW_W;

	logic [`MRD_ROW_W-1:0] wr_row;
	logic [`MRD_BANK_W-1:0] wr_bank;

	// --------------------------------------------------
	// write address split, same mapping as the reads
	// --------------------------------------------------
	mrd_div7 wr_div_i (
		.addr(wr.addr),
		.row(wr_row),
		.bank(wr_bank)
	);

	// --------------------------------------------------
	// seven independent banks
	// --------------------------------------------------
	for (genvar b = 0; b < `MRD_BANKS; b++)
	begin : g_bank
		cplx_t mem [ROWS];
		cplx_t rd_q;

		// write goes only to the addressed bank
		always_ff @(posedge clk)
		begin
			if (wr.en && wr_bank == `MRD_BANK_W'(b))
				mem[wr_row] <= wr.data;
		end

		// registered read, holds when not enabled
		always_ff @(posedge clk)
		begin
			if (rd_req.en[b])
				rd_q <= mem[rd_req.row[b]];
		end

		assign dout.d[b] = rd_q;
	end

endmodule

`default_nettype wire

// ==== source/mrd_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_rd_top (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  mrd_pkg::rd_cfg_t cfg,
	input  mrd_pkg::mem_wr_t wr,
	output mrd_pkg::bfly_t bfly,
	output logic rd_end
);

	import mrd_pkg::*;

	// sequencer to banks
	bank_rd_t rd_req;
	// banks back to the sequencer
	bank_dout_t dout;

	// --------------------------------------------------
	// read sequencer
	// --------------------------------------------------
	mrd_rd_ctrl rd_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.cfg(cfg),
		.rd_req(rd_req),
		.dout(dout),
		.bfly(bfly),
		.rd_end(rd_end)
	);

	// --------------------------------------------------
	// sample memory
	// --------------------------------------------------
	mrd_bank_ram bank_ram_i (
		.clk(clk),
		.rd_req(rd_req),
		.dout(dout),
		.wr(wr)
	);

endmodule

`default_nettype wire

// ==== testbench/mrd_rd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_rd_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic vld_s3,
	input  logic vld_s4,
	input  logic [`MRD_LANES-1:0][`MRD_BANK_W-1:0] map_bank,
	input  logic valid,
	input  logic rd_end,
	input  logic wr_en
);

	// tally read back by the testbench
	int n_fail = 0;
	logic clash;
	logic busy;

	// --------------------------------------------------
	// two lanes on one bank
	// --------------------------------------------------
	always_comb
	begin
		clash = 1'b0;
		for (int a = 0; a < `MRD_LANES; a++)
		begin
			for (int b = a + 1; b < `MRD_LANES; b++)
			begin
				if (map_bank[a] != `MRD_BANK_W'(`MRD_BANKS) && map_bank[a] == map_bank[b])
					clash = 1'b1;
			end
		end
	end

	// counting or reads still in flight
	assign busy = run | vld_s3 | vld_s4;

	// end pulse lines up with the last counted butterfly through the read pipeline
	end_after_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
		rd_end |-> ($past(valid) && !valid
			&& $past(run, `MRD_RD_DLY) && !$past(run, `MRD_RD_DLY-1)))
	else
	begin
		$error("end-of-read pulse not right after the last butterfly");
		n_fail++;
	end

	bank_clash_a: assert property (@(posedge clk) disable iff (!rst_n)
		vld_s3 |-> !clash)
	else
	begin
		$error("two lanes address the same bank in one cycle");
		n_fail++;
	end

	wr_in_pass_a: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !busy)
	else
	begin
		$error("write issued while a read pass is active");
		n_fail++;
	end

endmodule

`default_nettype wire

// ==== testbench/mrd_rd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrd_settings.svh"

module mrd_rd_tb;

	import mrd_pkg::*;

	localparam int CLK_NS = 4;
	localparam int RST_CYCLES = 16;
	localparam int N_ADDR = `MRD_BANKS << `MRD_ROW_W;
	localparam int N_PASS = 6;

	// one read pass, mid_start fires a stray start halfway through
	typedef struct packed {
		logic [2:0] radix;
		logic [`MRD_ADDR_W-1:0] span;
		logic mid_start;
	} pass_t;

	// no span is a multiple of 7, radix x span fits the frame
	localparam pass_t PASSES [N_PASS] = '{
		'{3'd5, 12'd12, 1'b0},
		'{3'd4, 12'd30, 1'b0},
		'{3'd3, 12'd100, 1'b1},
		'{3'd2, 12'd9, 1'b0},
		'{3'd5, 12'd1, 1'b0},
		'{3'd3, 12'd40, 1'b0}
	};

	logic clk;
	logic rst_n;
	logic start;
	rd_cfg_t cfg;
	mem_wr_t wr;
	bfly_t bfly;
	logic rd_end;

	// model copy of the frame, linear addresses
	cplx_t model [N_ADDR];
	integer seed;
	int n_checks;
	int n_errors;

	mrd_rd_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.cfg(cfg),
		.wr(wr),
		.bfly(bfly),
		.rd_end(rd_end)
	);

	bind mrd_rd_ctrl mrd_rd_checker checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.vld_s3(vld_s3),
		.vld_s4(vld_s4),
		.map_bank(map.bank),
		.valid(bfly.valid),
		.rd_end(rd_end),
		.wr_en(mrd_rd_tb.dut_i.wr.en)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_NS / 2);
			clk = ~clk;
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		n_checks++;
		if (got !== want)
		begin
			n_errors++;
			$display("Error: %s = %0h, expected %0h at %0t", name, got, want, $time);
		end
	endtask

	// no butterfly and no end pulse
	task automatic expect_idle();
		compare_value("bfly.valid", 64'(bfly.valid), 64'(0));
		compare_value("rd_end", 64'(rd_end), 64'(0));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			expect_idle();
		end
	endtask

	// lane k of butterfly j reads j + k*span, unused lanes read zero
	function automatic cplx_t expected_lane(input pass_t p, input int j, input int k);
		if (k < int'(p.radix))
			return model[j + k * int'(p.span)];
		return '0;
	endfunction

	// random frame through the write port
	task automatic load_banks();
		cplx_t d;
		for (int a = 0; a < N_ADDR; a++)
		begin
			@(negedge clk);
			expect_idle();
			d.re = `MRD_DATA_W'($random(seed));
			d.im = `MRD_DATA_W'($random(seed));
			model[a] = d;
			wr.en = 1'b1;
			wr.addr = `MRD_ADDR_W'(a);
			wr.data = d;
		end
		@(negedge clk);
		wr = '0;
	endtask

	// --------------------------------------------------
	// one pass, cycle c counted from the start pulse
	// --------------------------------------------------
	task automatic run_pass(input pass_t p);
		int c;
		int j;
		int n_valid;
		logic stray;
		logic exp_valid;
		c = 0;
		n_valid = 0;
		@(negedge clk);
		expect_idle();
		start = 1'b1;
		cfg.radix = p.radix;
		cfg.span = p.span;
		while (c <= int'(p.span) + `MRD_RD_DLY + 8)
		begin
			@(negedge clk);
			c++;
			// stray start with another config, must be ignored
			stray = p.mid_start && (c == int'(p.span) / 2);
			start = stray;
			cfg.radix = stray ? 3'd5 : p.radix;
			cfg.span = stray ? `MRD_ADDR_W'(13) : p.span;
			exp_valid = (c >= `MRD_RD_DLY) && (c < `MRD_RD_DLY + int'(p.span));
			compare_value("bfly.valid", 64'(bfly.valid), 64'(exp_valid));
			compare_value("rd_end", 64'(rd_end), 64'(c == `MRD_RD_DLY + int'(p.span)));
			if (bfly.valid === 1'b1)
				n_valid++;
			if (exp_valid)
			begin
				j = c - `MRD_RD_DLY;
				compare_value("bfly.radix", 64'(bfly.radix), 64'(p.radix));
				for (int k = 0; k < `MRD_LANES; k++)
				begin
					compare_value($sformatf("bfly.lane[%0d] of butterfly %0d", k, j),
						64'(bfly.lane[k]), 64'(expected_lane(p, j, k)));
				end
			end
			if (rd_end === 1'b1)
				break;
		end
		if (rd_end !== 1'b1)
		begin
			n_errors++;
			$display("no end-of-read pulse within %0d cycles of start (span %0d)", c, p.span);
		end
		compare_value("valid butterfly count", 64'(n_valid), 64'(p.span));
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		int n_assert;
		seed = 32'h8e76_df60;
		n_checks = 0;
		n_errors = 0;
		rst_n = 1'b0;
		start = 1'b0;
		cfg = '0;
		wr = '0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// quiet outputs before any start
		idle_cycles(2);
		load_banks();
		idle_cycles(2);
		for (int i = 0; i < N_PASS; i++)
		begin
			run_pass(PASSES[i]);
			idle_cycles(3);
		end
		n_assert = dut_i.rd_ctrl_i.checker_i.n_fail;
		$display("checks: %0d, value errors: %0d, assertion failures: %0d",
			n_checks, n_errors, n_assert);
		if (n_errors == 0 && n_assert == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// reset, load and every pass with slack
	initial
	begin
		int cycles;
		cycles = RST_CYCLES + N_ADDR;
		for (int i = 0; i < N_PASS; i++)
			cycles += int'(PASSES[i].span) + 20;
		#(cycles * CLK_NS);
		$display("watchdog expired, run did not finish within %0d cycles", cycles);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mrd_rd_top.f ====
+incdir+include
source/mrd_pkg.sv
source/mrd_div7.sv
source/mrd_pipe.sv
source/mrd_addr_gen.sv
source/mrd_rd_ctrl.sv
source/mrd_bank_ram.sv
source/mrd_rd_top.sv
testbench/mrd_rd_checker.sv
testbench/mrd_rd_tb.sv

// ==== Makefile ====
# Verilator build and run of the read-side testbench

VERILATOR ?= verilator
TOP       ?= mrd_rd_tb
FILELIST  ?= mrd_rd_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
SIM_ARGS  ?= +verilator+error+limit+1000

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
INCS := include/mrd_settings.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS SIM_ARGS"

$(BIN): $(SRCS) $(INCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "no verdict in $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
